// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_rv32_core
FILELIST = compile.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
rv32_pkg.sv
rv32_alu.sv
rv32_regfile.sv
rv32_decoder.sv
rv32_control.sv
rv32_core.sv
rv32_core_props.sv
tb_rv32_core.sv

// ==== rv32_alu.sv ====
`timescale 1ns/1ps

module rv32_alu import rv32_pkg::*; (
  input  word_t      a,
  input  word_t      b,
  input  alu_op_t    op,
  input  word_t      cmp_a,
  input  word_t      cmp_b,
  input  logic [2:0] funct3,
  output word_t      result,
  output logic       branch_taken
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    unique case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = word_t'($signed(a) < $signed(b));
      alu_sltu:   result = word_t'(a < b);
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // separate comparator so the target add runs alongside
  always_comb begin
    unique case (funct3)
      f3_beq:  branch_taken = (cmp_a == cmp_b);
      f3_bne:  branch_taken = (cmp_a != cmp_b);
      f3_blt:  branch_taken = ($signed(cmp_a) < $signed(cmp_b));
      f3_bge:  branch_taken = ($signed(cmp_a) >= $signed(cmp_b));
      f3_bltu: branch_taken = (cmp_a < cmp_b);
      f3_bgeu: branch_taken = (cmp_a >= cmp_b);
      default: branch_taken = 1'b0;  // reserved encodings fall through
    endcase
  end

endmodule

// ==== rv32_control.sv ====
`timescale 1ns/1ps

module rv32_control import rv32_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         ena,
  input  instr_class_t instr_class,
  input  logic         branch_taken,
  output logic         instr_load,
  output logic         operand_load,
  output logic         result_load,
  output logic         mem_data_load,
  output logic         pc_load,
  output logic         pc_jump,
  output logic         reg_write,
  output logic         mem_wr_ena,
  output logic         addr_sel,
  output wb_sel_t      wb_sel
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        taken_q;  // branch outcome held from execute
  logic        is_mem;
  logic        writes_rd;

  assign is_mem    = (instr_class == cls_load) || (instr_class == cls_store);
  assign writes_rd = instr_class inside {cls_alu, cls_lui, cls_load, cls_jal, cls_jalr};

  always_comb begin
    state_next = state;
    unique case (state)
      st_fetch:     state_next = st_decode;
      st_decode:    state_next = st_execute;
      st_execute:   state_next = is_mem ? st_memory : st_writeback;
      st_memory:    state_next = st_writeback;
      st_writeback: state_next = st_fetch;
      default:      state_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_fetch;
      taken_q <= 1'b0;
    end else if (ena) begin
      state <= state_next;
      if (state == st_execute) begin
        taken_q <= branch_taken;
      end
    end
  end

  // latch enables only fire on enabled cycles
  always_comb begin
    instr_load    = ena && (state == st_fetch);
    operand_load  = ena && (state == st_decode);
    result_load   = ena && (state == st_execute);
    mem_data_load = ena && (state == st_memory) && (instr_class == cls_load);
    mem_wr_ena    = ena && (state == st_memory) && (instr_class == cls_store);
    pc_load       = ena && (state == st_writeback);
    reg_write     = ena && (state == st_writeback) && writes_rd;
  end

  always_comb begin
    addr_sel = (state == st_memory);  // result latch drives the address
    pc_jump  = 1'b0;
    if (state == st_writeback) begin
      pc_jump = (instr_class == cls_jal) || (instr_class == cls_jalr) ||
                (instr_class == cls_branch && taken_q);
    end
  end

  always_comb begin
    unique case (instr_class)
      cls_load:          wb_sel = wb_mem;
      cls_jal, cls_jalr: wb_sel = wb_link;  // rd gets pc + 4
      default:           wb_sel = wb_alu;
    endcase
  end

endmodule

// ==== rv32_core.sv ====
`timescale 1ns/1ps

module rv32_core import rv32_pkg::*; #(
  parameter word_t pc_reset = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  ena,
  output word_t mem_addr,
  output word_t mem_wr_data,
  output logic  mem_wr_ena,
  input  word_t mem_rd_data,
  output word_t pc
);

  logic         instr_load, operand_load, result_load, mem_data_load;
  logic         pc_load, pc_jump, reg_write, addr_sel;
  wb_sel_t      wb_sel;
  instr_class_t instr_class;
  alu_op_t      alu_op;
  reg_addr_t    rs1, rs2, rd;
  word_t        imm;
  logic         use_pc, use_imm;
  logic         branch_taken;

  word_t instr_q;     // instruction latch
  word_t rs1_q;       // operand latches
  word_t rs2_q;
  word_t result_q;
  word_t mem_data_q;  // load data
  word_t rs1_data, rs2_data;
  word_t alu_a, alu_b, alu_result;
  word_t pc_plus4, target, wb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= pc_reset;
    end else if (pc_load) begin
      pc <= pc_jump ? target : pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_load)    instr_q    <= mem_rd_data;
    if (operand_load)  rs1_q      <= rs1_data;
    if (operand_load)  rs2_q      <= rs2_data;
    if (result_load)   result_q   <= alu_result;
    if (mem_data_load) mem_data_q <= mem_rd_data;
  end

  assign alu_a    = use_pc ? pc : rs1_q;
  assign alu_b    = use_imm ? imm : rs2_q;
  assign pc_plus4 = pc + 32'd4;  // link value and sequential pc
  assign target   = (instr_class == cls_jalr) ? {result_q[31:1], 1'b0} : result_q;

  always_comb begin
    unique case (wb_sel)
      wb_mem:  wb_data = mem_data_q;
      wb_link: wb_data = pc_plus4;
      default: wb_data = result_q;
    endcase
  end

  assign mem_addr    = addr_sel ? result_q : pc;
  assign mem_wr_data = rs2_q;

  rv32_control control_i (
    .clk(clk), .rst(rst), .ena(ena),
    .instr_class(instr_class), .branch_taken(branch_taken),
    .instr_load(instr_load), .operand_load(operand_load),
    .result_load(result_load), .mem_data_load(mem_data_load),
    .pc_load(pc_load), .pc_jump(pc_jump), .reg_write(reg_write),
    .mem_wr_ena(mem_wr_ena), .addr_sel(addr_sel), .wb_sel(wb_sel)
  );

  rv32_decoder decoder_i (
    .instr(instr_q), .instr_class(instr_class), .alu_op(alu_op),
    .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .use_pc(use_pc), .use_imm(use_imm)
  );

  rv32_regfile regfile_i (
    .clk(clk), .wr_ena(reg_write), .wr_addr(rd), .wr_data(wb_data),
    .rd_addr0(rs1), .rd_addr1(rs2), .rd_data0(rs1_data), .rd_data1(rs2_data)
  );

  rv32_alu alu_i (
    .a(alu_a), .b(alu_b), .op(alu_op),
    .cmp_a(rs1_q), .cmp_b(rs2_q), .funct3(instr_q[14:12]),
    .result(alu_result), .branch_taken(branch_taken)
  );

endmodule

// ==== rv32_core_props.sv ====
`timescale 1ns/1ps

module rv32_core_props import rv32_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  ena,
  input logic  mem_wr_ena,
  input word_t pc
);

  wr_single_cycle: assert property (@(posedge clk) disable iff (rst) mem_wr_ena |=> !mem_wr_ena)
    else $error("mem_wr_ena high in two consecutive cycles");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // stalled edge leaves pc alone
  pc_held: assert property (@(posedge clk) disable iff (rst) !ena |=> $stable(pc))
    else $error("pc changed while ena was low");

  wr_low_in_reset: assert property (@(posedge clk) rst |-> !mem_wr_ena)
    else $error("mem_wr_ena high during reset");

endmodule

bind rv32_core rv32_core_props props_i (
  .clk(clk), .rst(rst), .ena(ena), .mem_wr_ena(mem_wr_ena), .pc(pc)
);

// ==== rv32_decoder.sv ====
`timescale 1ns/1ps

module rv32_decoder import rv32_pkg::*; (
  input  word_t        instr,
  output instr_class_t instr_class,
  output alu_op_t      alu_op,
  output reg_addr_t    rs1,
  output reg_addr_t    rs2,
  output reg_addr_t    rd,
  output word_t        imm,
  output logic         use_pc,
  output logic         use_imm
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;  // bit 30 picks sub and sra
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    unique case (funct3)
      f3_add:  arith_op = (alt && opcode == op_reg) ? alu_sub : alu_add;  // no subi
      f3_sll:  arith_op = alu_sll;
      f3_slt:  arith_op = alu_slt;
      f3_sltu: arith_op = alu_sltu;
      f3_xor:  arith_op = alu_xor;
      f3_srl:  arith_op = alt ? alu_sra : alu_srl;
      f3_or:   arith_op = alu_or;
      f3_and:  arith_op = alu_and;
      default: arith_op = alu_add;
    endcase
  end

  always_comb begin
    instr_class = cls_nop;
    alu_op      = alu_add;  // address and target adds
    imm         = '0;
    use_pc      = 1'b0;
    use_imm     = 1'b1;
    unique case (opcode)
      op_reg: begin
        instr_class = cls_alu;
        alu_op      = arith_op;
        use_imm     = 1'b0;
      end
      op_imm: begin
        instr_class = cls_alu;
        alu_op      = arith_op;
        imm         = {{20{instr[31]}}, instr[31:20]};
      end
      op_lui: begin
        instr_class = cls_lui;
        alu_op      = alu_pass_b;
        imm         = {instr[31:12], 12'b0};
      end
      op_load: begin
        instr_class = cls_load;
        imm         = {{20{instr[31]}}, instr[31:20]};
      end
      op_store: begin
        instr_class = cls_store;
        imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      op_branch: begin
        instr_class = cls_branch;
        use_pc      = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      op_jal: begin
        instr_class = cls_jal;
        use_pc      = 1'b1;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      op_jalr: begin
        instr_class = cls_jalr;
        imm         = {{20{instr[31]}}, instr[31:20]};
      end
      default: instr_class = cls_nop;  // retires with pc + 4
    endcase
  end

endmodule

// ==== rv32_pkg.sv ====
package rv32_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;  // data word or byte address
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes of the kept instruction set
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

  // funct3 of the alu instructions
  localparam logic [2:0] f3_add  = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;  // srl and sra split by bit 30
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b  // lui passes the u immediate through
  } alu_op_t;

  typedef enum logic [2:0] {
    cls_alu, cls_lui, cls_load, cls_store,
    cls_branch, cls_jal, cls_jalr, cls_nop
  } instr_class_t;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_memory, st_writeback
  } ctrl_state_t;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;

endpackage

// ==== rv32_regfile.sv ====
`timescale 1ns/1ps

module rv32_regfile import rv32_pkg::*; (
  input  logic      clk,
  input  logic      wr_ena,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data,
  input  reg_addr_t rd_addr0,
  input  reg_addr_t rd_addr1,
  output word_t     rd_data0,
  output word_t     rd_data1
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 is hardwired to zero
  always_comb begin
    rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  end

endmodule

// ==== tb_rv32_core.sv ====
`timescale 1ns/1ps

module tb_rv32_core;
  import rv32_pkg::*;

  localparam int prog_len  = 152;  // 120 random words then 31 dump stores and the self-loop
  localparam int max_cycle = prog_len * 5 * 2 + 200;
  localparam int dump_word = 448;  // dump area starts at byte 0x700
  localparam word_t end_pc = (prog_len - 1) * 4;

  logic clk = 1'b0;
  logic rst;
  logic ena;
  word_t mem_addr, mem_wr_data, mem_rd_data, pc;
  logic mem_wr_ena;

  word_t mem [512];
  word_t mmem [512];  // model memory
  word_t mregs [32];  // model register file
  word_t mpc;
  word_t store_q [$];  // expected stores as address then data pairs
  logic [15:0] lfsr = 16'd20543;
  logic stall_on = 1'b0;
  int cycles = 0;
  int stores_seen = 0;
  int stores_expected = 0;

  rv32_core #(.pc_reset('0)) rv32_core_i (
    .clk(clk), .rst(rst), .ena(ena),
    .mem_addr(mem_addr), .mem_wr_data(mem_wr_data), .mem_wr_ena(mem_wr_ena),
    .mem_rd_data(mem_rd_data), .pc(pc)
  );

  always #10 clk = ~clk;

  assign mem_rd_data = mem[mem_addr[10:2]];  // combinational read

  always @(posedge clk) begin
    if (mem_wr_ena) mem[mem_addr[10:2]] <= mem_wr_data;
  end

  // one step per bit with taps 16 14 13 11
  function automatic word_t take_bits(int n);
    word_t v;
    logic fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("error: time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t enc_b(int off, reg_addr_t s2, reg_addr_t s1, logic [2:0] f3);
    logic [12:0] im;
    im = 13'(off * 4);
    return {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], op_branch};
  endfunction

  task automatic build_program();
    int i, off, kind;
    logic [2:0] f3;
    logic alt;
    reg_addr_t rd, ra, rb;
    logic [11:0] im;
    for (int a = 0; a < 512; a++) mem[a] = a * 32'h0100_0193 + 32'h2545_f491;
    for (int r = 1; r < 32; r++) mem[r-1] = {12'(take_bits(12)), 5'd0, 3'd0, 5'(r), op_imm};
    i = 31;
    while (i < 120) begin
      kind = take_bits(4);
      rd = 5'(take_bits(5));
      ra = 5'(take_bits(5));
      rb = 5'(take_bits(5));
      f3 = 3'(take_bits(3));
      alt = 1'(take_bits(1));
      off = 1 + take_bits(2);
      if (i + off > 120) off = 120 - i;
      im = 12'h400 | 12'(take_bits(8) << 2);  // word in 0x400 to 0x7fc
      if (kind <= 4) begin
        alt = alt && (f3 == 3'd0 || f3 == 3'd5);
        mem[i] = {1'b0, alt, 5'd0, rb, ra, f3, rd, op_reg};
      end else if (kind <= 7) begin
        if (f3 == 3'd1) im = {7'd0, rb};
        else if (f3 == 3'd5) im = {1'b0, alt, 5'd0, rb};
        else im = 12'(take_bits(12));
        mem[i] = {im, ra, f3, rd, op_imm};
      end else if (kind == 8) mem[i] = {20'(take_bits(20)), rd, op_lui};
      else if (kind <= 10) mem[i] = {im, 5'd0, 3'b010, rd, op_load};
      else if (kind == 11) mem[i] = {im[11:5], rb, 5'd0, 3'b010, im[4:0], op_store};
      else if (kind == 12) begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;  // no branch encodings 2 and 3
        mem[i] = enc_b(off, rb, ra, f3);
      end else if (kind == 13) begin
        im = 12'(off * 4);  // small forward jal
        mem[i] = {1'b0, im[10:1], 1'b0, 8'd0, rd, op_jal};
      end else if (kind == 14 && i < 119) begin
        rb = 5'(1 + take_bits(4));
        off = 1 + take_bits(2);
        if (i + 1 + off > 120) off = 119 - i;
        im = 12'((i + 1 + off) * 4 + alt);  // bit 0 set at times
        mem[i] = {im, 5'd0, 3'd0, rb, op_imm};
        i++;
        mem[i] = {12'd0, rb, 3'd0, rd, op_jalr};
      end else mem[i] = {25'(take_bits(25)), 7'b0001011};  // unknown opcode
      i++;
    end
    for (int r = 1; r < 32; r++) begin
      im = 12'((dump_word + r) * 4);
      mem[119 + r] = {im[11:5], 5'(r), 5'd0, 3'b010, im[4:0], op_store};
    end
    mem[prog_len-1] = 32'h0000_006f;  // jal x0 0
    mmem = mem;
  endtask

  task automatic step_model(output int lat);
    word_t w, a, b, nxt, t, ii;
    reg_addr_t rd;
    w = mmem[mpc[10:2]];
    rd = w[11:7];
    a = mregs[w[19:15]];
    b = mregs[w[24:20]];
    ii = {{20{w[31]}}, w[31:20]};
    nxt = mpc + 4;
    lat = 4;
    case (w[6:0])
      op_reg: mregs[rd] = ref_alu(w[14:12], w[30], a, b);
      op_imm: mregs[rd] = ref_alu(w[14:12], w[30] && w[14:12] == 3'd5, a, ii);
      op_lui: mregs[rd] = {w[31:12], 12'd0};
      op_load: begin
        lat = 5;
        t = a + ii;
        mregs[rd] = mmem[t[10:2]];
      end
      op_store: begin
        lat = 5;
        t = a + {{20{w[31]}}, w[31:25], w[11:7]};
        mmem[t[10:2]] = b;
        store_q.push_back(t);
        store_q.push_back(b);
        stores_expected++;
      end
      op_branch: begin
        case (w[14:12])
          3'd0: t = word_t'(a == b);
          3'd1: t = word_t'(a != b);
          3'd4: t = word_t'($signed(a) < $signed(b));
          3'd5: t = word_t'($signed(a) >= $signed(b));
          3'd6: t = word_t'(a < b);
          default: t = word_t'(a >= b);
        endcase
        if (t[0]) nxt = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      op_jal: begin
        mregs[rd] = mpc + 4;
        nxt = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      op_jalr: begin
        nxt = (a + ii) & ~32'd1;  // target taken before rd is written
        mregs[rd] = mpc + 4;
      end
      default: ;
    endcase
    mregs[0] = '0;
    mpc = nxt;
  endtask

  task automatic wait_enabled(int n);
    int k;
    k = 0;
    while (k < n) begin
      @(posedge clk);
      if (ena) k++;
    end
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycle) begin
      $display("timeout: core did not reach the end of the program in %0d cycles", max_cycle);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // random stalls once stall_on is set
  always @(posedge clk) begin
    #1;
    if (!rst) ena = !(stall_on && take_bits(2) == 0);
  end

  always @(negedge clk) begin
    if (mem_wr_ena === 1'b1) begin
      if (store_q.size() < 2) begin
        $display("unexpected store to address %h at time %0t", mem_addr, $time);
        $display("SIMULATION FAILED");
        $fatal(1);
      end
      check("store address", mem_addr, store_q.pop_front());
      check("store data", mem_wr_data, store_q.pop_front());
      stores_seen++;
    end
  end

  initial begin
    int lat, retired;
    rst = 1'b1;
    ena = 1'b1;  // enabled through reset so only reset keeps the port quiet
    retired = 0;
    for (int r = 0; r < 32; r++) mregs[r] = '0;
    build_program();
    mpc = '0;
    @(negedge clk);
    check("pc in reset", pc, '0);
    check("mem_wr_ena in reset", {31'b0, mem_wr_ena}, '0);
    @(posedge clk);
    #1;
    rst = 1'b0;
    while (mpc != end_pc) begin
      check("pc", pc, mpc);
      step_model(lat);
      retired++;
      if (retired >= prog_len / 2) stall_on = 1'b1;
      wait_enabled(lat);
    end
    check("final pc", pc, end_pc);
    check("store count", stores_seen, stores_expected);
    for (int r = 1; r < 32; r++) check($sformatf("x%0d dump", r), mem[dump_word + r], mregs[r]);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
